/* rtl/cache_bus_pkg.sv */
package cache_bus_pkg;

  // cpu request, valid travels beside it
  typedef struct packed {
    logic                 write;  // 1 for store
    cache_cfg_pkg::addr_t addr;
    cache_cfg_pkg::word_t wdata;
    cache_cfg_pkg::strb_t wstrb;
  } cpu_req_t;  // 69 bits

  // tag lookup result, valid for the live request address
  typedef struct packed {
    logic                 hit;
    cache_cfg_pkg::way_t  hit_way;       // lowest matching way
    cache_cfg_pkg::way_t  victim_way;    // round-robin pick
    logic                 victim_dirty;  // victim holds valid modified data
    cache_cfg_pkg::tag_t  victim_tag;    // for the write-back address
  } lookup_t;  // 32 bits

  // line store commands from the miss engine
  typedef struct packed {
    logic                hit_wr;    // merge cpu write into the line
    logic                rf_beat;   // one refill beat accepted
    logic                rf_last;   // final refill beat, tag update
    logic                wb_load;   // victim line into the write-back register
    logic                wb_shift;  // write-back beat accepted
    cache_cfg_pkg::way_t way;       // target way for all of the above
  } line_ctrl_t;  // 8 bits

endpackage

/* rtl/cache_cfg_pkg.sv */
package cache_cfg_pkg;

  // cache geometry
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;                          // cpu word and memory beat
  localparam int STRB_W     = WORD_W / 8;                  // one strobe bit per byte
  localparam int LINE_WORDS = 8;                           // also beats per burst
  localparam int OFFSET_W   = 5;                           // byte offset inside a line
  localparam int INDEX_W    = 3;
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W; // 24 bits
  localparam int NUM_SETS   = 1 << INDEX_W;
  localparam int LINE_W     = WORD_W * LINE_WORDS;         // 256 bit line
  localparam int SEL_W      = $clog2(LINE_WORDS);
  localparam int WAY_W      = 3;                           // room for up to 8 ways
  localparam int BEAT_W     = 4;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [STRB_W-1:0]  strb_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [SEL_W-1:0]   word_sel_t;  // word position within a line
  typedef logic [LINE_W-1:0]  line_t;
  typedef logic [WAY_W-1:0]   way_t;
  typedef logic [BEAT_W-1:0]  beat_cnt_t;

  // address fields, tag | index | word | byte
  function automatic tag_t addr_tag(addr_t a);
    return a[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic index_t addr_index(addr_t a);
    return a[OFFSET_W +: INDEX_W];
  endfunction

  function automatic word_sel_t addr_word(addr_t a);
    return a[OFFSET_W-1 -: SEL_W];  // drops the byte-in-word bits
  endfunction

  // line aligned burst address
  function automatic addr_t line_base(tag_t t, index_t i);
    return {t, i, {OFFSET_W{1'b0}}};
  endfunction

endpackage

/* rtl/cache_lookup.sv */
`timescale 1ns/1ps

module cache_lookup #(
  parameter int NUM_WAYS = 6
) (
  input  logic                      clk,
  input  logic                      rst,
  input  cache_cfg_pkg::addr_t      req_addr,
  input  cache_bus_pkg::line_ctrl_t line_ctrl,
  output cache_bus_pkg::lookup_t    lookup
);
  import cache_cfg_pkg::*;
  import cache_bus_pkg::*;

  tag_t                req_tag;
  index_t              req_index;
  logic [NUM_WAYS-1:0] way_hit;
  way_t                rr_q;      // next victim

  // per-way state, one bit per set
  logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
  logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];
  tag_t                tag_q   [NUM_WAYS][NUM_SETS];

  assign req_tag   = addr_tag(req_addr);
  assign req_index = addr_index(req_addr);

  // compare all ways in parallel
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = valid_q[w][req_index] && (tag_q[w][req_index] == req_tag);
    end
  end

  always_comb begin
    lookup     = '0;
    lookup.hit = |way_hit;
    // walk down so the lowest matching way is left standing
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        lookup.hit_way = way_t'(w);
      end
    end
    lookup.victim_way   = rr_q;
    lookup.victim_dirty = valid_q[rr_q][req_index] && dirty_q[rr_q][req_index];
    lookup.victim_tag   = tag_q[rr_q][req_index];  // only meaningful when dirty
  end

  // valid, dirty and the round-robin pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
      rr_q <= '0;
    end else begin
      if (line_ctrl.rf_last) begin
        valid_q[line_ctrl.way][req_index] <= 1'b1;
        dirty_q[line_ctrl.way][req_index] <= 1'b0;  // fresh line matches memory
        // pointer moves once per completed refill, wraps at the way count
        if (rr_q == way_t'(NUM_WAYS - 1)) begin
          rr_q <= '0;
        end else begin
          rr_q <= rr_q + way_t'(1);
        end
      end else if (line_ctrl.hit_wr) begin
        dirty_q[line_ctrl.way][req_index] <= 1'b1;
      end
    end
  end

  // tag written together with the last refill beat
  always_ff @(posedge clk) begin
    if (line_ctrl.rf_last) begin
      tag_q[line_ctrl.way][req_index] <= req_tag;
    end
  end

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
  parameter int NUM_WAYS = 6  // 2 to 8
) (
  input  logic                    clk,
  input  logic                    rst,
  // cpu request
  input  logic                    req_valid,
  input  cache_bus_pkg::cpu_req_t cpu_req,
  output logic                    req_ready,
  // cpu response
  output logic                    rsp_valid,
  output cache_cfg_pkg::word_t    rsp_data,
  input  logic                    rsp_ready,
  // memory read, refill bursts
  output logic                    rd_req_valid,
  output cache_cfg_pkg::addr_t    rd_req_addr,
  input  logic                    rd_req_ready,
  input  logic                    rd_rsp_valid,
  input  cache_cfg_pkg::word_t    rd_rsp_data,
  input  logic                    rd_rsp_last,
  output logic                    rd_rsp_ready,
  // memory write, write-back bursts
  output logic                    wr_req_valid,
  output cache_cfg_pkg::addr_t    wr_req_addr,
  input  logic                    wr_req_ready,
  output logic                    wr_data_valid,
  output cache_cfg_pkg::word_t    wr_data,
  output logic                    wr_data_last,
  input  logic                    wr_data_ready
);
  import cache_bus_pkg::*;

  lookup_t    lookup;     // tag lookup to miss engine
  line_ctrl_t line_ctrl;  // miss engine to both stores

  cache_lookup #(
    .NUM_WAYS (NUM_WAYS)
  ) lookup_i (
    .clk       (clk),
    .rst       (rst),
    .req_addr  (cpu_req.addr),
    .line_ctrl (line_ctrl),
    .lookup    (lookup)
  );

  miss_engine engine_i (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_write     (cpu_req.write),
    .req_addr      (cpu_req.addr),
    .lookup        (lookup),
    .req_ready     (req_ready),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rd_req_valid  (rd_req_valid),
    .rd_req_addr   (rd_req_addr),
    .rd_req_ready  (rd_req_ready),
    .rd_rsp_valid  (rd_rsp_valid),
    .rd_rsp_last   (rd_rsp_last),
    .rd_rsp_ready  (rd_rsp_ready),
    .wr_req_valid  (wr_req_valid),
    .wr_req_addr   (wr_req_addr),
    .wr_req_ready  (wr_req_ready),
    .wr_data_ready (wr_data_ready),
    .wr_data_valid (wr_data_valid),
    .wr_data_last  (wr_data_last),
    .line_ctrl     (line_ctrl)
  );

  line_data #(
    .NUM_WAYS (NUM_WAYS)
  ) data_i (
    .clk         (clk),
    .rst         (rst),
    .req_addr    (cpu_req.addr),
    .req_wdata   (cpu_req.wdata),
    .req_wstrb   (cpu_req.wstrb),
    .rd_rsp_data (rd_rsp_data),
    .line_ctrl   (line_ctrl),
    .rsp_data    (rsp_data),
    .wr_data     (wr_data)
  );

endmodule

/* rtl/line_data.sv */
`timescale 1ns/1ps

module line_data #(
  parameter int NUM_WAYS = 6
) (
  input  logic                      clk,
  input  logic                      rst,
  input  cache_cfg_pkg::addr_t      req_addr,
  input  cache_cfg_pkg::word_t      req_wdata,
  input  cache_cfg_pkg::strb_t      req_wstrb,
  input  cache_cfg_pkg::word_t      rd_rsp_data,
  input  cache_bus_pkg::line_ctrl_t line_ctrl,
  output cache_cfg_pkg::word_t      rsp_data,
  output cache_cfg_pkg::word_t      wr_data
);
  import cache_cfg_pkg::*;
  import cache_bus_pkg::*;

  line_t     lines_q [NUM_WAYS][NUM_SETS];
  line_t     cur_line;     // target way, current set
  line_t     merged_line;
  line_t     wb_q;         // write-back shift register
  index_t    req_index;
  word_sel_t req_sel;
  word_t     cur_word;
  word_t     byte_mask;

  assign req_index = addr_index(req_addr);
  assign req_sel   = addr_word(req_addr);
  assign cur_line  = lines_q[line_ctrl.way][req_index];
  assign cur_word  = cur_line[req_sel*WORD_W +: WORD_W];

  // expand strobes to a bit mask
  always_comb begin
    for (int b = 0; b < STRB_W; b++) begin
      byte_mask[b*8 +: 8] = {8{req_wstrb[b]}};
    end
  end

  // only strobed bytes of the addressed word change
  always_comb begin
    merged_line = cur_line;
    merged_line[req_sel*WORD_W +: WORD_W] = (cur_word & ~byte_mask) | (req_wdata & byte_mask);
  end

  always_ff @(posedge clk) begin
    if (line_ctrl.hit_wr) begin
      lines_q[line_ctrl.way][req_index] <= merged_line;
    end else if (line_ctrl.rf_beat) begin
      // beat enters at the top, after eight beats word 0 sits at the bottom
      lines_q[line_ctrl.way][req_index] <= {rd_rsp_data, cur_line[LINE_W-1:WORD_W]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_q <= '0;
    end else if (line_ctrl.wb_load) begin
      wb_q <= cur_line;  // victim line, way is the victim here
    end else if (line_ctrl.wb_shift) begin
      wb_q <= {{WORD_W{1'b0}}, wb_q[LINE_W-1:WORD_W]};  // next word down
    end
  end

  assign rsp_data = cur_word;         // follows the live request address
  assign wr_data  = wb_q[WORD_W-1:0]; // lowest word is the current beat

endmodule

/* rtl/miss_engine.sv */
`timescale 1ns/1ps

module miss_engine (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req_valid,
  input  logic                      req_write,
  input  cache_cfg_pkg::addr_t      req_addr,
  input  cache_bus_pkg::lookup_t    lookup,
  output logic                      req_ready,
  output logic                      rsp_valid,
  input  logic                      rsp_ready,
  output logic                      rd_req_valid,
  output cache_cfg_pkg::addr_t      rd_req_addr,
  input  logic                      rd_req_ready,
  input  logic                      rd_rsp_valid,
  input  logic                      rd_rsp_last,
  output logic                      rd_rsp_ready,
  output logic                      wr_req_valid,
  output cache_cfg_pkg::addr_t      wr_req_addr,
  input  logic                      wr_req_ready,
  input  logic                      wr_data_ready,
  output logic                      wr_data_valid,
  output logic                      wr_data_last,
  output cache_bus_pkg::line_ctrl_t line_ctrl
);
  import cache_cfg_pkg::*;
  import cache_bus_pkg::*;

  typedef enum logic [2:0] {
    idle,
    wb_req,   // write-back address phase
    wb_data,  // eight victim beats out
    rf_req,   // refill address phase
    rf_data,  // eight beats in
    hit_wr,
    hit_rd,
    respond   // read word held for the cpu
  } state_t;

  state_t    state_q;
  state_t    state_d;
  beat_cnt_t beat_q;
  logic      last_beat;
  logic      wb_fire;
  logic      rf_fire;
  logic      miss_phase;

  assign wb_fire    = (state_q == wb_data) && wr_data_ready;
  assign rf_fire    = (state_q == rf_data) && rd_rsp_valid;
  assign last_beat  = (beat_q == beat_cnt_t'(LINE_WORDS - 1));
  assign miss_phase = (state_q == wb_req) || (state_q == wb_data) ||
                      (state_q == rf_req) || (state_q == rf_data);

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (req_valid) begin
          if (lookup.hit) begin
            state_d = req_write ? hit_wr : hit_rd;
          end else if (lookup.victim_dirty) begin
            state_d = wb_req;  // victim goes out first
          end else begin
            state_d = rf_req;
          end
        end
      end
      wb_req:  if (wr_req_ready) state_d = wb_data;
      wb_data: if (wb_fire && last_beat) state_d = rf_req;
      rf_req:  if (rd_req_ready) state_d = rf_data;
      rf_data: begin
        // replay as a hit once the line is in
        if (rf_fire && rd_rsp_last) begin
          state_d = req_write ? hit_wr : hit_rd;
        end
      end
      hit_wr:  state_d = idle;     // merge happens this cycle
      hit_rd:  state_d = respond;
      respond: if (rsp_ready) state_d = idle;
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // write-back beat counter, restarts on every write-back
  always_ff @(posedge clk) begin
    if (rst || (state_q == wb_req)) begin
      beat_q <= '0;
    end else if (wb_fire) begin
      beat_q <= beat_q + beat_cnt_t'(1);
    end
  end

  // cpu side
  assign req_ready = (state_q == hit_wr) || (state_q == hit_rd);
  assign rsp_valid = (state_q == respond);

  // memory side, addresses are line aligned
  assign rd_req_valid  = (state_q == rf_req);
  assign rd_req_addr   = line_base(addr_tag(req_addr), addr_index(req_addr));
  assign rd_rsp_ready  = (state_q == rf_data);
  assign wr_req_valid  = (state_q == wb_req);
  assign wr_req_addr   = line_base(lookup.victim_tag, addr_index(req_addr));
  assign wr_data_valid = (state_q == wb_data);
  assign wr_data_last  = (state_q == wb_data) && last_beat;

  // line store strobes
  always_comb begin
    line_ctrl          = '0;
    line_ctrl.hit_wr   = (state_q == hit_wr);
    line_ctrl.rf_beat  = rf_fire;
    line_ctrl.rf_last  = rf_fire && rd_rsp_last;
    line_ctrl.wb_load  = (state_q == wb_req) && wr_req_ready;  // snapshot on address accept
    line_ctrl.wb_shift = wb_fire;
    line_ctrl.way      = miss_phase ? lookup.victim_way : lookup.hit_way;
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

/* sources.f */
rtl/cache_cfg_pkg.sv
rtl/cache_bus_pkg.sv
rtl/cache_lookup.sv
rtl/miss_engine.sv
rtl/line_data.sv
rtl/dcache_top.sv
tests/mem_model.sv
tests/dcache_tb.sv

/* tests/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;
  import cache_cfg_pkg::*;
  import cache_bus_pkg::*;

  localparam int NUM_WAYS = 6;
  localparam int TIMEOUT  = 2000;  // cycles per wait

  // one table row, expected burst counts are per operation
  typedef struct packed {
    logic      write;
    addr_t     addr;
    word_t     wdata;
    strb_t     wstrb;
    word_t     exp_data;
    beat_cnt_t exp_rd;
    beat_cnt_t exp_wb;
    addr_t     exp_wb_addr;
  } op_t;

  logic clk = 1'b0;
  logic rst;
  logic req_valid;
  cpu_req_t cpu_req;
  logic req_ready, rsp_valid, rsp_ready;
  word_t rsp_data, rd_rsp_data, wr_data;
  logic rd_req_valid, rd_req_ready, rd_rsp_valid, rd_rsp_last, rd_rsp_ready;
  logic wr_req_valid, wr_req_ready, wr_data_valid, wr_data_last, wr_data_ready;
  addr_t rd_req_addr, wr_req_addr, last_rd_addr, last_wb_addr;
  int rd_bursts, wb_bursts;
  int data_errors = 0;
  int burst_errors = 0;
  int timeouts = 0;
  integer seed = 32'h3f76fe8c;
  op_t ops[$];
  word_t merged;
  word_t shadow [addr_t];  // words the cpu has written, by word address
  addr_t wb_base;          // write-back burst under watch
  int    wb_beat;

  always #20 clk = ~clk;

  dcache_top #(.NUM_WAYS(NUM_WAYS)) dut_i (.*);

  mem_model mem_i (.*);

  function automatic word_t model_word(addr_t a);
    return word_t'(a * 32'h9e3779b1);
  endfunction

  // what memory must hold once the cache writes this word back
  function automatic word_t expect_word(addr_t a);
    if (shadow.exists(a)) return shadow[a];
    return model_word(a);
  endfunction

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t s);
    word_t r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) r[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return r;
  endfunction

  task automatic add_op(logic wr, addr_t a, word_t wd, strb_t s, word_t exp,
                        int n_rd, int n_wb, addr_t wb_a);
    ops.push_back('{wr, a, wd, s, exp, beat_cnt_t'(n_rd), beat_cnt_t'(n_wb), wb_a});
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      data_errors++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      data_errors++;
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      burst_errors++;
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      burst_errors++;
    end
  endtask

  task automatic note_timeout(string what);
    $display("timed out waiting for %s", what);
    timeouts++;
  endtask

  // every write-back beat carries the word the cpu last saw there
  always @(posedge clk) begin
    if (rst) begin
      wb_beat <= 0;
    end else if (wr_req_valid && wr_req_ready) begin
      wb_base <= wr_req_addr;
      wb_beat <= 0;
    end else if (wr_data_valid && wr_data_ready) begin
      check_word("wr_data", wr_data, expect_word(wb_base + addr_t'(4 * wb_beat)));
      check_flag("wr_data_last", wr_data_last, wb_beat == LINE_WORDS - 1);
      wb_beat <= wb_beat + 1;
    end
  end

  task automatic run_op(op_t op);
    int rd0;
    int wb0;
    int n;
    addr_t wa;
    rd0 = rd_bursts;
    wb0 = wb_bursts;
    wa  = op.addr & ~addr_t'(3);
    if (op.write) shadow[wa] = merge_bytes(expect_word(wa), op.wdata, op.wstrb);
    @(posedge clk);
    req_valid <= 1'b1;
    cpu_req   <= '{write: op.write, addr: op.addr, wdata: op.wdata, wstrb: op.wstrb};
    n = 0;
    @(negedge clk);
    while (!req_ready && n < TIMEOUT) begin
      n++;
      @(negedge clk);
    end
    if (!req_ready) begin
      note_timeout("req_ready");
      return;
    end
    @(posedge clk);
    req_valid <= 1'b0;  // address stays put, rsp_data follows it
    if (!op.write) begin
      n = 0;
      @(negedge clk);
      while (!rsp_valid && n < TIMEOUT) begin
        n++;
        @(negedge clk);
      end
      if (!rsp_valid) begin
        note_timeout("rsp_valid");
        return;
      end
      check_word("rsp_data", rsp_data, op.exp_data);
      repeat ($random(seed) & 3) @(posedge clk);  // cpu stalls the response
      @(posedge clk);
      rsp_ready <= 1'b1;
      @(posedge clk);
      rsp_ready <= 1'b0;
    end
    check_count("rd_bursts", rd_bursts - rd0, int'(op.exp_rd));
    check_count("wb_bursts", wb_bursts - wb0, int'(op.exp_wb));
    if (op.exp_rd != 0) check_addr("rd_req_addr", last_rd_addr, op.addr & ~addr_t'(31));
    if (op.exp_wb != 0) check_addr("wr_req_addr", last_wb_addr, op.exp_wb_addr);
  endtask

  initial begin
    rst       <= 1'b1;
    req_valid <= 1'b0;
    cpu_req   <= '0;
    rsp_ready <= 1'b0;
    merged = merge_bytes(model_word(32'h1008), 32'ha5a5_5a5a, 4'b0101);
    add_op(0, 32'h1004, '0, '0, model_word(32'h1004), 1, 0, '0);  // cold miss
    add_op(0, 32'h1018, '0, '0, model_word(32'h1018), 0, 0, '0);  // hit
    add_op(1, 32'h1008, 32'ha5a5_5a5a, 4'b0101, '0, 0, 0, '0);     // partial write hit
    add_op(0, 32'h1008, '0, '0, merged, 0, 0, '0);
    // fill the other ways of set 0, the last read evicts the dirty line
    for (int k = 1; k < NUM_WAYS; k++) begin
      add_op(0, 32'h1000 + 32'h100 * k, '0, '0, model_word(32'h1000 + 32'h100 * k), 1, 0, '0);
    end
    add_op(0, 32'h1600, '0, '0, model_word(32'h1600), 1, 1, 32'h1000);
    add_op(0, 32'h1008, '0, '0, merged, 1, 0, '0);                 // back through refill
    add_op(0, 32'h101c, '0, '0, model_word(32'h101c), 0, 0, '0);
    // mixed traffic in set 2
    add_op(1, 32'h2044, 32'hdead_beef, 4'b1111, '0, 1, 0, '0);
    add_op(0, 32'h2044, '0, '0, 32'hdead_beef, 0, 0, '0);
    add_op(1, 32'h2040, 32'h1122_3344, 4'b1000, '0, 0, 0, '0);
    add_op(0, 32'h2040, '0, '0, merge_bytes(model_word(32'h2040), 32'h1122_3344, 4'b1000),
           0, 0, '0);

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (req_ready || rsp_valid || rd_req_valid || rd_rsp_ready || wr_req_valid ||
        wr_data_valid) begin
      $display("control outputs not all low after reset");
      data_errors++;
    end
    foreach (ops[i]) begin
      if (timeouts == 0) run_op(ops[i]);
    end

    $display("errors: %0d data, %0d burst, %0d timeout", data_errors, burst_errors, timeouts);
    if (data_errors == 0 && burst_errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tests/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_req_valid,
  input  cache_cfg_pkg::addr_t rd_req_addr,
  output logic                 rd_req_ready,
  output logic                 rd_rsp_valid,
  output cache_cfg_pkg::word_t rd_rsp_data,
  output logic                 rd_rsp_last,
  input  logic                 rd_rsp_ready,
  input  logic                 wr_req_valid,
  input  cache_cfg_pkg::addr_t wr_req_addr,
  output logic                 wr_req_ready,
  input  logic                 wr_data_valid,
  input  cache_cfg_pkg::word_t wr_data,
  input  logic                 wr_data_last,
  output logic                 wr_data_ready,
  output int                   rd_bursts,   // accepted refill requests
  output int                   wb_bursts,   // accepted write-back requests
  output cache_cfg_pkg::addr_t last_rd_addr,
  output cache_cfg_pkg::addr_t last_wb_addr
);
  import cache_cfg_pkg::*;

  word_t  mem [addr_t];   // only written-back words live here
  integer seed;
  logic   rd_busy;
  int     rd_beat;
  addr_t  rd_base;
  logic   wb_busy;
  int     wb_beat;
  addr_t  wb_base;

  // untouched memory reads as a hash of the address
  function automatic word_t read_word(addr_t a);
    if (mem.exists(a)) return mem[a];
    return word_t'(a * 32'h9e3779b1);
  endfunction

  function automatic logic gap_free();
    return (($random(seed) & 3) != 0);  // about one cycle in four stalls
  endfunction

  task automatic read_side();
    logic taken;
    taken = rd_rsp_valid && rd_rsp_ready;
    if (rd_req_valid && rd_req_ready) begin
      rd_busy = 1'b1;
      rd_base = rd_req_addr;
      rd_beat = 0;
      rd_bursts <= rd_bursts + 1;
      last_rd_addr <= rd_req_addr;
    end
    if (taken) begin
      rd_beat = rd_beat + 1;
      if (rd_beat == LINE_WORDS) rd_busy = 1'b0;
    end
    rd_req_ready <= !rd_busy && gap_free();
    if (rd_rsp_valid && !taken) begin
      // beat held until taken
    end else if (rd_busy && gap_free()) begin
      rd_rsp_valid <= 1'b1;
      rd_rsp_data  <= read_word(rd_base + addr_t'(4 * rd_beat));
      rd_rsp_last  <= (rd_beat == LINE_WORDS - 1);
    end else begin
      rd_rsp_valid <= 1'b0;
      rd_rsp_last  <= 1'b0;
    end
  endtask

  task automatic write_side();
    if (wr_req_valid && wr_req_ready) begin
      wb_busy = 1'b1;
      wb_base = wr_req_addr;
      wb_beat = 0;
      wb_bursts <= wb_bursts + 1;
      last_wb_addr <= wr_req_addr;
    end else if (wb_busy && wr_data_valid && wr_data_ready) begin
      mem[wb_base + addr_t'(4 * wb_beat)] = wr_data;  // capture for later refills
      wb_beat = wb_beat + 1;
      if (wr_data_last) wb_busy = 1'b0;
    end
    wr_req_ready  <= !wb_busy && gap_free();
    wr_data_ready <= wb_busy && gap_free();
  endtask

  initial begin
    seed = 32'h3f76fe8c;
    rd_busy = 1'b0;
    wb_busy = 1'b0;
    rd_beat = 0;
    wb_beat = 0;
    rd_base = '0;
    wb_base = '0;
    rd_req_ready <= 1'b0;
    rd_rsp_valid <= 1'b0;
    rd_rsp_data <= '0;
    rd_rsp_last <= 1'b0;
    wr_req_ready <= 1'b0;
    wr_data_ready <= 1'b0;
    rd_bursts <= 0;
    wb_bursts <= 0;
    last_rd_addr <= '0;
    last_wb_addr <= '0;
    forever begin
      @(posedge clk);
      if (rst) begin
        rd_busy = 1'b0;
        wb_busy = 1'b0;
        rd_req_ready <= 1'b0;
        rd_rsp_valid <= 1'b0;
        rd_rsp_last <= 1'b0;
        wr_req_ready <= 1'b0;
        wr_data_ready <= 1'b0;
      end else begin
        read_side();
        write_side();
      end
    end
  end

endmodule
